// ==== src/c16_mem_pkg.sv ====
// shared widths, zero-page pointer map and slot constants for the c16 memory glue
// every module of the memory hub pulls these in with a wildcard import
package c16_mem_pkg;

	// ----------------------------------------
	// bus and memory widths
	// ----------------------------------------

	// cpu address as rebuilt from the multiplexed dram bus
	localparam int CPU_ADDR_W = 16;

	// byte index of the download stream, also the loader ram byte address
	localparam int LOAD_ADDR_W = 25;

	// word address of the external 16 bit ram
	localparam int RAM_ADDR_W = 24;

	// one data byte, c16 data bus and loader payload
	localparam int BYTE_W = 8;

	// ram data word, two byte lanes
	localparam int RAM_DATA_W = 16;

	// ----------------------------------------
	// slot timing
	// ----------------------------------------

	// slot counter width, 16 clocks per memory cycle
	// msb set means the cpu owns the ram, msb clear means the loader does
	localparam int SLOT_CNT_W = 4;

	// ----------------------------------------
	// zero-page shadow map
	// ----------------------------------------

	// basic pointers that get patched after a prg injection
	localparam int ZP_PTR_COUNT = 4;

	// low byte address of each pointer, the high byte follows at +1
	// index 0 is the start-of-variables pointer at 0x2d
	localparam logic [ZP_PTR_COUNT-1:0][CPU_ADDR_W-1:0] ZP_BASE_ADDRS = {
		16'h009d,
		16'h0031,
		16'h002f,
		16'h002d
	};

	// overlay value when the address is not one of the shadowed bytes
	localparam logic [BYTE_W-1:0] ZP_MISS_DATA = 8'hff;

	// a prg file starts with its load address, low byte first
	localparam int HEADER_BYTES = 2;

endpackage

// ==== src/c16_bus_capture.sv ====
// demultiplexes the c16 dram bus into a 16 bit cpu address and runs the slot timer
// the slot counter restarts on every RAS fall so both halves stay locked to the c16
`timescale 1ns/1ps

module c16_bus_capture (
	input  logic                               clk28,
	input  logic                               reset,
	input  logic                               ras_n_i,
	input  logic                               cas_n_i,
	input  logic [c16_mem_pkg::BYTE_W-1:0]     a_i,
	output logic [c16_mem_pkg::CPU_ADDR_W-1:0] cpu_addr_o,
	output logic                               cpu_slot_o,
	output logic                               to_loader_o,
	output logic                               to_cpu_o
);
	import c16_mem_pkg::*;

	// strobe synchronizers, bit 0 is the first stage
	logic [2:0] ras_sync;
	logic [2:0] cas_sync;
	logic ras_fall;
	logic cas_fall;
	// address bus delayed to line up with the synchronized strobes
	logic [BYTE_W-1:0] a_s1;
	logic [BYTE_W-1:0] a_s2;
	logic [BYTE_W-1:0] a_row;
	logic [BYTE_W-1:0] a_col;
	logic [SLOT_CNT_W-1:0] slot_cnt;
	logic [SLOT_CNT_W-1:0] slot_next;

	// ----------------------------------------
	// strobe sync and address latches
	// ----------------------------------------

	always_ff @(posedge clk28) begin
		if (reset) begin
			// strobes idle high
			ras_sync <= '1;
			cas_sync <= '1;
		end else begin
			ras_sync <= {ras_sync[1:0], ras_n_i};
			cas_sync <= {cas_sync[1:0], cas_n_i};
		end
	end

	// fall seen between the second and third stage
	assign ras_fall = ras_sync[2] & ~ras_sync[1];
	assign cas_fall = cas_sync[2] & ~cas_sync[1];

	always_ff @(posedge clk28) begin
		a_s1 <= a_i;
		a_s2 <= a_s1;
		// row byte is the low half of the cpu address, column byte the high half
		if (ras_fall)
			a_row <= a_s2;
		if (cas_fall)
			a_col <= a_s2;
	end

	assign cpu_addr_o = {a_col, a_row};

	// ----------------------------------------
	// slot timer
	// ----------------------------------------

	assign slot_next = ras_fall ? '0 : slot_cnt + 1'b1;

	always_ff @(posedge clk28) begin
		if (reset)
			slot_cnt <= '0;
		else
			slot_cnt <= slot_next;
	end

	assign cpu_slot_o = slot_cnt[SLOT_CNT_W-1];
	// edge pulses sit in the last cycle before the half changes
	assign to_loader_o = slot_cnt[SLOT_CNT_W-1] & ~slot_next[SLOT_CNT_W-1];
	assign to_cpu_o = ~slot_cnt[SLOT_CNT_W-1] & slot_next[SLOT_CNT_W-1];

endmodule

// ==== src/prg_injector.sv ====
// turns a downloaded prg byte stream into ram writes during the loader half
// first two bytes give the load address, every later byte lands one address higher
`timescale 1ns/1ps

module prg_injector (
	input  logic                                clk28,
	input  logic                                reset,
	input  logic                                dl_active_i,
	input  logic                                dl_wr_i,
	input  logic [c16_mem_pkg::LOAD_ADDR_W-1:0] dl_addr_i,
	input  logic [c16_mem_pkg::BYTE_W-1:0]      dl_data_i,
	input  logic                                to_loader_i,
	input  logic                                to_cpu_i,
	output logic                                ld_we_o,
	output logic [c16_mem_pkg::LOAD_ADDR_W-1:0] ld_addr_o,
	output logic [c16_mem_pkg::BYTE_W-1:0]      ld_data_o,
	output logic                                done_o,
	output logic [c16_mem_pkg::CPU_ADDR_W-1:0]  end_addr_o
);
	import c16_mem_pkg::*;

	logic hdr_wr;
	logic payload_wr;
	// byte waiting for the next loader half
	logic pending;
	logic [BYTE_W-1:0] pend_data;
	logic [LOAD_ADDR_W-1:0] load_addr;
	logic active_q;

	// header bytes go to the address register, the rest is payload
	assign hdr_wr = dl_active_i & dl_wr_i & (dl_addr_i < LOAD_ADDR_W'(HEADER_BYTES));
	assign payload_wr = dl_active_i & dl_wr_i & ~hdr_wr;

	// ----------------------------------------
	// write sequencing
	// ----------------------------------------

	always_ff @(posedge clk28) begin
		if (reset) begin
			pending <= 1'b0;
			ld_we_o <= 1'b0;
			load_addr <= '0;
			active_q <= 1'b0;
			done_o <= 1'b0;
		end else begin
			active_q <= dl_active_i;
			// end of download, one clock pulse
			done_o <= active_q & ~dl_active_i;

			// loader half starts, pending byte goes out for the whole half
			if (to_loader_i) begin
				ld_we_o <= pending;
				pending <= 1'b0;
			end

			// cpu half starts, step past the byte just written
			if (to_cpu_i) begin
				if (ld_we_o)
					load_addr <= load_addr + 1'b1;
				ld_we_o <= 1'b0;
			end

			// load address from the file header, low byte then high byte
			if (hdr_wr) begin
				if (dl_addr_i[0] == 1'b0)
					load_addr[BYTE_W-1:0] <= dl_data_i;
				else
					load_addr[LOAD_ADDR_W-1:BYTE_W] <=
						{{(LOAD_ADDR_W-2*BYTE_W){1'b0}}, dl_data_i};
			end

			// a strobe in the same clock as the half change waits one slot
			if (payload_wr)
				pending <= 1'b1;
		end
	end

	// byte buffers
	always_ff @(posedge clk28) begin
		if (payload_wr)
			pend_data <= dl_data_i;
		if (to_loader_i & pending)
			ld_data_o <= pend_data;
	end

	assign ld_addr_o = load_addr;
	// already one past the last written byte once its write half has closed
	assign end_addr_o = load_addr[CPU_ADDR_W-1:0];

endmodule

// ==== src/zp_shadow.sv ====
// eight zero-page shadow bytes holding the basic end pointers
// preset to the program end after a download, writable by the cpu, overlaid on reads
`timescale 1ns/1ps

module zp_shadow (
	input  logic                               clk28,
	input  logic                               reset,
	input  logic [c16_mem_pkg::CPU_ADDR_W-1:0] cpu_addr_i,
	input  logic                               rw_i,
	input  logic                               cas_n_i,
	input  logic [c16_mem_pkg::BYTE_W-1:0]     cpu_wdata_i,
	input  logic                               preset_i,
	input  logic [c16_mem_pkg::CPU_ADDR_W-1:0] preset_val_i,
	output logic                               hit_o,
	output logic [c16_mem_pkg::BYTE_W-1:0]     ovl_data_o
);
	import c16_mem_pkg::*;

	logic [CPU_ADDR_W-1:0] ptr [ZP_PTR_COUNT];
	// per pointer decode of the low and high byte address
	logic [ZP_PTR_COUNT-1:0] lo_sel;
	logic [ZP_PTR_COUNT-1:0] hi_sel;
	logic [2:0] cas_sync;
	logic cas_fall_q;

	// ----------------------------------------
	// address decode and read overlay
	// ----------------------------------------

	always_comb begin
		for (int i = 0; i < ZP_PTR_COUNT; i++) begin
			lo_sel[i] = (cpu_addr_i == ZP_BASE_ADDRS[i]);
			hi_sel[i] = (cpu_addr_i == ZP_BASE_ADDRS[i] + CPU_ADDR_W'(1));
		end
	end

	assign hit_o = |{lo_sel, hi_sel};

	always_comb begin
		ovl_data_o = ZP_MISS_DATA;
		for (int i = 0; i < ZP_PTR_COUNT; i++) begin
			if (lo_sel[i])
				ovl_data_o = ptr[i][BYTE_W-1:0];
			if (hi_sel[i])
				ovl_data_o = ptr[i][CPU_ADDR_W-1:BYTE_W];
		end
	end

	// ----------------------------------------
	// cpu write pulse
	// ----------------------------------------

	// same sync depth as the column latch, so the pulse comes with the full address
	always_ff @(posedge clk28) begin
		if (reset) begin
			cas_sync <= '1;
			cas_fall_q <= 1'b0;
		end else begin
			cas_sync <= {cas_sync[1:0], cas_n_i};
			cas_fall_q <= cas_sync[2] & ~cas_sync[1];
		end
	end

	// preset wins over a cpu write in the same clock
	always_ff @(posedge clk28) begin
		for (int i = 0; i < ZP_PTR_COUNT; i++) begin
			if (preset_i) begin
				ptr[i] <= preset_val_i;
			end else if (cas_fall_q & ~rw_i) begin
				if (lo_sel[i])
					ptr[i][BYTE_W-1:0] <= cpu_wdata_i;
				if (hi_sel[i])
					ptr[i][CPU_ADDR_W-1:BYTE_W] <= cpu_wdata_i;
			end
		end
	end

endmodule

// ==== src/mem_slot_mux.sv ====
// shares the 16 bit ram between the cpu half and the loader half of each slot
// folds the cpu address for 16k mode and steers byte lanes in both directions
`timescale 1ns/1ps

module mem_slot_mux (
	input  logic                                cpu_slot_i,
	input  logic [c16_mem_pkg::CPU_ADDR_W-1:0]  cpu_addr_i,
	input  logic                                rw_i,
	input  logic                                cas_n_i,
	input  logic [c16_mem_pkg::BYTE_W-1:0]      cpu_wdata_i,
	input  logic                                mem_16k_i,
	input  logic                                ld_we_i,
	input  logic [c16_mem_pkg::LOAD_ADDR_W-1:0] ld_addr_i,
	input  logic [c16_mem_pkg::BYTE_W-1:0]      ld_data_i,
	input  logic                                zp_hit_i,
	input  logic [c16_mem_pkg::BYTE_W-1:0]      zp_data_i,
	input  logic [c16_mem_pkg::RAM_DATA_W-1:0]  ram_rdata_i,
	output logic [c16_mem_pkg::RAM_ADDR_W-1:0]  ram_addr_o,
	output logic [c16_mem_pkg::RAM_DATA_W-1:0]  ram_wdata_o,
	output logic                                ram_we_o,
	output logic                                ram_oe_o,
	output logic [1:0]                          ram_ds_o,
	output logic [c16_mem_pkg::BYTE_W-1:0]      cpu_rdata_o
);
	import c16_mem_pkg::*;

	logic [RAM_ADDR_W-1:0] cpu_word_64k;
	logic [RAM_ADDR_W-1:0] cpu_word_16k;
	logic [RAM_ADDR_W-1:0] cpu_word;
	logic [RAM_ADDR_W-1:0] ld_word;
	// byte address bit 0 of whoever owns the slot
	logic lane_hi;
	logic [BYTE_W-1:0] wr_byte;
	logic [BYTE_W-1:0] ram_byte;

	// ----------------------------------------
	// address folding
	// ----------------------------------------

	// 64k, plain word address
	assign cpu_word_64k = {{(RAM_ADDR_W-CPU_ADDR_W+1){1'b0}}, cpu_addr_i[CPU_ADDR_W-1:1]};
	// 16k, bits 15:14 dropped, the two gaps mirror the 16k banks
	assign cpu_word_16k = {{(RAM_ADDR_W-CPU_ADDR_W+1){1'b0}}, 1'b0, cpu_addr_i[13:7],
		1'b0, cpu_addr_i[6:1]};
	assign cpu_word = mem_16k_i ? cpu_word_16k : cpu_word_64k;
	assign ld_word = ld_addr_i[LOAD_ADDR_W-1:1];

	// ----------------------------------------
	// slot select
	// ----------------------------------------

	assign ram_addr_o = cpu_slot_i ? cpu_word : ld_word;
	assign lane_hi = cpu_slot_i ? cpu_addr_i[0] : ld_addr_i[0];
	assign wr_byte = cpu_slot_i ? cpu_wdata_i : ld_data_i;

	// cpu accesses follow CAS, loader only ever writes
	assign ram_we_o = cpu_slot_i ? (~cas_n_i & ~rw_i) : ld_we_i;
	assign ram_oe_o = cpu_slot_i & ~cas_n_i & rw_i;

	// same byte on both lanes, the strobes pick one
	assign ram_wdata_o = {wr_byte, wr_byte};
	assign ram_ds_o = {lane_hi, ~lane_hi};

	// ----------------------------------------
	// read path
	// ----------------------------------------

	assign ram_byte = cpu_addr_i[0] ? ram_rdata_i[RAM_DATA_W-1:BYTE_W] :
		ram_rdata_i[BYTE_W-1:0];

	// shadowed zero-page bytes hide the ram contents
	assign cpu_rdata_o = zp_hit_i ? zp_data_i : ram_byte;

endmodule

// ==== src/c16_memory_hub.sv ====
// memory glue between the c16 dram bus, the prg loader and a word-wide ram
// wires the bus capture, prg injector, zero-page shadow and slot mux together
`timescale 1ns/1ps

module c16_memory_hub (
	input  logic                                clk28,
	input  logic                                reset,
	// c16 dram bus
	input  logic                                ras_n_i,
	input  logic                                cas_n_i,
	input  logic                                rw_i,
	input  logic [c16_mem_pkg::BYTE_W-1:0]      a_i,
	input  logic [c16_mem_pkg::BYTE_W-1:0]      cpu_wdata_i,
	output logic [c16_mem_pkg::BYTE_W-1:0]      cpu_rdata_o,
	// loader byte stream
	input  logic                                dl_active_i,
	input  logic                                dl_wr_i,
	input  logic [c16_mem_pkg::LOAD_ADDR_W-1:0] dl_addr_i,
	input  logic [c16_mem_pkg::BYTE_W-1:0]      dl_data_i,
	input  logic                                mem_16k_i,
	// ram port
	output logic [c16_mem_pkg::RAM_ADDR_W-1:0]  ram_addr_o,
	output logic [c16_mem_pkg::RAM_DATA_W-1:0]  ram_wdata_o,
	output logic                                ram_we_o,
	output logic                                ram_oe_o,
	output logic [1:0]                          ram_ds_o,
	input  logic [c16_mem_pkg::RAM_DATA_W-1:0]  ram_rdata_i
);
	import c16_mem_pkg::*;

	logic [CPU_ADDR_W-1:0] cpu_addr;
	logic cpu_slot;
	logic to_loader;
	logic to_cpu;
	logic ld_we;
	logic [LOAD_ADDR_W-1:0] ld_addr;
	logic [BYTE_W-1:0] ld_data;
	logic dl_done;
	logic [CPU_ADDR_W-1:0] end_addr;
	logic zp_hit;
	logic [BYTE_W-1:0] zp_data;

	// ----------------------------------------
	// bus side
	// ----------------------------------------

	c16_bus_capture capture0 (
		.clk28       (clk28),
		.reset       (reset),
		.ras_n_i     (ras_n_i),
		.cas_n_i     (cas_n_i),
		.a_i         (a_i),
		.cpu_addr_o  (cpu_addr),
		.cpu_slot_o  (cpu_slot),
		.to_loader_o (to_loader),
		.to_cpu_o    (to_cpu)
	);

	// loader writes, done pulse presets the basic pointers
	prg_injector inject0 (
		.clk28       (clk28),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.to_loader_i (to_loader),
		.to_cpu_i    (to_cpu),
		.ld_we_o     (ld_we),
		.ld_addr_o   (ld_addr),
		.ld_data_o   (ld_data),
		.done_o      (dl_done),
		.end_addr_o  (end_addr)
	);

	zp_shadow shadow0 (
		.clk28        (clk28),
		.reset        (reset),
		.cpu_addr_i   (cpu_addr),
		.rw_i         (rw_i),
		.cas_n_i      (cas_n_i),
		.cpu_wdata_i  (cpu_wdata_i),
		.preset_i     (dl_done),
		.preset_val_i (end_addr),
		.hit_o        (zp_hit),
		.ovl_data_o   (zp_data)
	);

	// ----------------------------------------
	// ram side
	// ----------------------------------------

	mem_slot_mux mux0 (
		.cpu_slot_i  (cpu_slot),
		.cpu_addr_i  (cpu_addr),
		.rw_i        (rw_i),
		.cas_n_i     (cas_n_i),
		.cpu_wdata_i (cpu_wdata_i),
		.mem_16k_i   (mem_16k_i),
		.ld_we_i     (ld_we),
		.ld_addr_i   (ld_addr),
		.ld_data_i   (ld_data),
		.zp_hit_i    (zp_hit),
		.zp_data_i   (zp_data),
		.ram_rdata_i (ram_rdata_i),
		.ram_addr_o  (ram_addr_o),
		.ram_wdata_o (ram_wdata_o),
		.ram_we_o    (ram_we_o),
		.ram_oe_o    (ram_oe_o),
		.ram_ds_o    (ram_ds_o),
		.cpu_rdata_o (cpu_rdata_o)
	);

endmodule

// ==== bench/ram_word_model.sv ====
// behavioral 16 bit word ram for the memory hub bench
// byte strobes on write, read data follows oe by one clock
`timescale 1ns/1ps

module ram_word_model (
	input  logic                               clk28,
	input  logic [c16_mem_pkg::RAM_ADDR_W-1:0] addr_i,
	input  logic [c16_mem_pkg::RAM_DATA_W-1:0] wdata_i,
	input  logic                               we_i,
	input  logic                               oe_i,
	input  logic [1:0]                         ds_i,
	output logic [c16_mem_pkg::RAM_DATA_W-1:0] rdata_o
);
	import c16_mem_pkg::*;

	// 64k words, enough for 64k and 16k cpu maps and the loaded program
	logic [RAM_DATA_W-1:0] mem [65536];
	logic [15:0] idx;

	// only the low word address bits are decoded
	assign idx = addr_i[15:0];

	// ----------------------------------------
	// power-up contents
	// ----------------------------------------

	initial begin
		// scrambled fill, every address bit changes the word
		for (int i = 0; i < 65536; i++)
			mem[i] = 16'(i * 32'h9e37 + 32'h5a3c);
		rdata_o = '0;
	end

	// ----------------------------------------
	// access
	// ----------------------------------------

	always @(posedge clk28) begin
		if (we_i) begin
			// bit 1 is the high lane
			if (ds_i[1])
				mem[idx][15:8] <= wdata_i[15:8];
			if (ds_i[0])
				mem[idx][7:0] <= wdata_i[7:0];
		end
		// read data holds until the next oe cycle
		if (oe_i)
			rdata_o <= mem[idx];
	end

endmodule

// ==== bench/tb_c16_memory_hub.sv ====
// testbench for the c16 memory hub, runs a prg download and c16 bus cycles on a word ram
// expected values come from reference functions for folding, lanes and shadow bytes
`timescale 1ns/1ps

module tb_c16_memory_hub;
	import c16_mem_pkg::*;

	// test length, the timeout is derived from it
	localparam int PAYLOAD_LEN = 40;
	localparam int STROBE_GAP = 24;
	localparam int DRAIN_CYCLES = 48;
	localparam int BUS_CYCLES = 12;
	localparam int TEST_CYCLES = 16 + (PAYLOAD_LEN + HEADER_BYTES) * (STROBE_GAP + 1)
		+ DRAIN_CYCLES + 8 + BUS_CYCLES * 16 + 16;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;
	localparam logic [15:0] LOAD_ADDR = 16'h1001;

	logic clk28;
	logic reset;
	// c16 bus
	logic ras_n;
	logic cas_n;
	logic rw;
	logic [7:0] a_bus;
	logic [7:0] cpu_wdata;
	logic [7:0] cpu_rdata;
	// loader
	logic dl_active;
	logic dl_wr;
	logic [24:0] dl_addr;
	logic [7:0] dl_data;
	logic mem_16k;
	// ram port
	logic [23:0] ram_addr;
	logic [15:0] ram_wdata;
	logic ram_we;
	logic ram_oe;
	logic [1:0] ram_ds;
	logic [15:0] ram_rdata;

	int error_count;
	int check_count;
	int cycle_count;
	int ld_write_cycles;
	logic [7:0] payload [PAYLOAD_LEN];

	c16_memory_hub dut0 (
		.clk28       (clk28),
		.reset       (reset),
		.ras_n_i     (ras_n),
		.cas_n_i     (cas_n),
		.rw_i        (rw),
		.a_i         (a_bus),
		.cpu_wdata_i (cpu_wdata),
		.cpu_rdata_o (cpu_rdata),
		.dl_active_i (dl_active),
		.dl_wr_i     (dl_wr),
		.dl_addr_i   (dl_addr),
		.dl_data_i   (dl_data),
		.mem_16k_i   (mem_16k),
		.ram_addr_o  (ram_addr),
		.ram_wdata_o (ram_wdata),
		.ram_we_o    (ram_we),
		.ram_oe_o    (ram_oe),
		.ram_ds_o    (ram_ds),
		.ram_rdata_i (ram_rdata)
	);

	ram_word_model ram0 (
		.clk28   (clk28),
		.addr_i  (ram_addr),
		.wdata_i (ram_wdata),
		.we_i    (ram_we),
		.oe_i    (ram_oe),
		.ds_i    (ram_ds),
		.rdata_o (ram_rdata)
	);

	// 8 ns period
	initial clk28 = 1'b0;
	always #4 clk28 = ~clk28;

	// ----------------------------------------
	// reference model
	// ----------------------------------------

	function automatic logic [23:0] word_64k(input logic [15:0] a);
		return {9'd0, a[15:1]};
	endfunction

	// 16k map, gaps at word bits 14 and 6
	function automatic logic [23:0] word_16k(input logic [15:0] a);
		return {9'd0, 1'b0, a[13:7], 1'b0, a[6:1]};
	endfunction

	function automatic logic [23:0] word_loader(input logic [24:0] a);
		return a[24:1];
	endfunction

	function automatic logic [7:0] lane_byte(input logic [15:0] w, input logic hi);
		return hi ? w[15:8] : w[7:0];
	endfunction

	// pointer low bytes at 2d 2f 31 9d, high byte one above
	function automatic logic [7:0] shadow_byte(input logic [15:0] a, input logic [15:0] ptr);
		if (a == 16'h002d || a == 16'h002f || a == 16'h0031 || a == 16'h009d)
			return ptr[7:0];
		return ptr[15:8];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
		end
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------

	// one 16 clock c16 memory cycle, cas low covers the first half of the cpu slot
	task automatic bus_cycle(input logic [15:0] addr, input logic write,
		input logic [7:0] wdata, output logic [7:0] rdata);
		rdata = '0;
		for (int step = 0; step < 16; step++) begin
			@(posedge clk28);
			#1;
			if (step == 0) begin
				ras_n = 1'b0;
				a_bus = addr[7:0];
				rw = ~write;
				cpu_wdata = wdata;
			end else if (step == 2) begin
				cas_n = 1'b0;
				a_bus = addr[15:8];
			end else if (step == 8) begin
				ras_n = 1'b1;
			end else if (step == 15) begin
				cas_n = 1'b1;
				rw = 1'b1;
			end
			// ram data is back one clock after oe
			if (step == 14) begin
				@(negedge clk28);
				rdata = cpu_rdata;
			end
		end
	endtask

	task automatic read_check(input logic [15:0] addr, input logic [7:0] expected);
		logic [7:0] rd;
		bus_cycle(addr, 1'b0, 8'h00, rd);
		check_value($sformatf("cpu_rdata_o @%h", addr), 32'(rd), 32'(expected));
	endtask

	task automatic send_byte(input int idx, input logic [7:0] data);
		repeat (STROBE_GAP) @(posedge clk28);
		#1;
		dl_wr = 1'b1;
		dl_addr = 25'(idx);
		dl_data = data;
		@(posedge clk28);
		#1;
		dl_wr = 1'b0;
	endtask

	task automatic run_download();
		@(posedge clk28);
		#1;
		dl_active = 1'b1;
		// header, load address low byte first
		send_byte(0, LOAD_ADDR[7:0]);
		send_byte(1, LOAD_ADDR[15:8]);
		for (int i = 0; i < PAYLOAD_LEN; i++)
			send_byte(i + HEADER_BYTES, payload[i]);
		// last byte still needs its loader half
		repeat (DRAIN_CYCLES) @(posedge clk28);
		#1;
		dl_active = 1'b0;
		// done pulse and pointer preset land within two clocks
		repeat (4) @(posedge clk28);
	endtask

	task automatic check_ram_image();
		logic [24:0] baddr;
		logic [23:0] word;
		logic [15:0] data;
		for (int i = 0; i < PAYLOAD_LEN; i++) begin
			baddr = 25'(LOAD_ADDR) + 25'(i);
			word = word_loader(baddr);
			data = ram0.mem[word[15:0]];
			check_value($sformatf("ram byte %h", baddr), 32'(lane_byte(data, baddr[0])),
				32'(payload[i]));
		end
	endtask

	// ----------------------------------------
	// loader write monitor
	// ----------------------------------------

	always @(negedge clk28) begin
		if (!reset && dl_active && ram_we) begin
			ld_write_cycles++;
			check_value("ram_wdata_o lanes", 32'(ram_wdata[15:8]), 32'(ram_wdata[7:0]));
			check_value("ram_ds_o one-hot", 32'($onehot(ram_ds)), 32'd1);
		end
	end

	always @(posedge clk28) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// main sequence
	// ----------------------------------------

	initial begin
		logic [7:0] rd;
		logic [7:0] wbyte;
		logic [15:0] addr;
		logic [15:0] end_addr;
		logic [23:0] word;
		logic [15:0] data;

		void'($urandom(32'h1938_565a));
		error_count = 0;
		check_count = 0;
		cycle_count = 0;
		ld_write_cycles = 0;
		reset = 1'b1;
		ras_n = 1'b1;
		cas_n = 1'b1;
		rw = 1'b1;
		a_bus = '0;
		cpu_wdata = '0;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		mem_16k = 1'b0;
		for (int i = 0; i < PAYLOAD_LEN; i++)
			payload[i] = 8'($urandom);

		repeat (16) @(posedge clk28);
		#1;
		reset = 1'b0;
		@(negedge clk28);
		check_value("ram_we_o", 32'(ram_we), 32'd0);
		check_value("ram_oe_o", 32'(ram_oe), 32'd0);

		// prg injection, 8 write clocks per payload byte
		run_download();
		check_ram_image();
		check_value("loader write cycles", 32'(ld_write_cycles), 32'(PAYLOAD_LEN * 8));

		// shadow pointers preset to one past the program
		end_addr = LOAD_ADDR + 16'(PAYLOAD_LEN);
		read_check(16'h002d, shadow_byte(16'h002d, end_addr));
		read_check(16'h002e, shadow_byte(16'h002e, end_addr));
		read_check(16'h009d, shadow_byte(16'h009d, end_addr));
		read_check(16'h009e, shadow_byte(16'h009e, end_addr));

		// cpu write to one shadow byte leaves its neighbour alone
		wbyte = 8'($urandom);
		bus_cycle(16'h0031, 1'b1, wbyte, rd);
		read_check(16'h0031, wbyte);
		read_check(16'h0032, shadow_byte(16'h0032, end_addr));

		// 16k folding on a cpu write
		@(posedge clk28);
		#1;
		mem_16k = 1'b1;
		addr = 16'h0200 + 16'($urandom % 32'hfe00);
		wbyte = 8'($urandom);
		bus_cycle(addr, 1'b1, wbyte, rd);
		word = word_16k(addr);
		data = ram0.mem[word[15:0]];
		check_value($sformatf("ram 16k byte %h", addr), 32'(lane_byte(data, addr[0])),
			32'(wbyte));
		mem_16k = 1'b0;

		// 64k reads, two inside the program and two anywhere
		read_check(16'h1004, payload[3]);
		read_check(16'h1007, payload[6]);
		for (int i = 0; i < 2; i++) begin
			addr = 16'h0200 + 16'($urandom % 32'hfe00);
			word = word_64k(addr);
			data = ram0.mem[word[15:0]];
			read_check(addr, lane_byte(data, addr[0]));
		end

		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== c16_memory_hub.f ====
src/c16_mem_pkg.sv
src/c16_bus_capture.sv
src/prg_injector.sv
src/zp_shadow.sv
src/mem_slot_mux.sv
src/c16_memory_hub.sv
bench/ram_word_model.sv
bench/tb_c16_memory_hub.sv

// ==== Makefile ====
# Verilator build and run for the c16 memory hub testbench

TOP = tb_c16_memory_hub

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f c16_memory_hub.f -o $(TOP)

# status comes from the pass line in the simulator output
run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'SIMULATION PASSED'

clean:
	rm -rf obj_dir
